//--- design/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // the array is split into four equal banks
  localparam int NUM_BANKS   = 4;
  // bank select comes from the top of the request address
  localparam int BANK_SEL_W  = 2;

  // each bank stores 256 codewords
  localparam int BANK_DEPTH  = 256;
  localparam int BANK_ADDR_W = 8;

  // full request address is the bank select on top of the in-bank address
  localparam int ADDR_W      = BANK_SEL_W + BANK_ADDR_W;

  // error counters stick at all ones once they fill up
  localparam int CNT_W       = 8;

  // command that travels with every request down the bank pipe
  // a NOP is never forwarded to a bank, it is dropped at the input stage
  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_READ  = 2'd1,
    CMD_WRITE = 2'd2
  } rw_cmd_e;

endpackage

//--- design/secded_pkg.sv
package secded_pkg;

  // payload carried by each memory word
  localparam int DATA_W = 16;
  // five hamming bits plus one overall parity bit on top
  localparam int CHK_W  = 6;
  localparam int HAM_W  = CHK_W - 1;
  // codeword layout is {check, data}, data in the low bits
  localparam int CODE_W = DATA_W + CHK_W;

  // position of data bit idx in the classic hamming numbering
  // data fills positions 3..21 that are not powers of two, check bits own the rest
  function automatic logic [HAM_W-1:0] data_pos(int unsigned idx);
    logic [HAM_W-1:0] pos;
    int unsigned      n;
    pos = '0;
    n   = 0;
    for (int p = 3; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (n == idx) pos = HAM_W'(p);
        n++;
      end
    end
    return pos;
  endfunction

  // check bits for a data word
  // hamming bit b covers every data bit whose position has bit b set
  function automatic logic [CHK_W-1:0] secded_encode(logic [DATA_W-1:0] data);
    logic [CHK_W-1:0] chk;
    logic [HAM_W-1:0] pos;
    chk = '0;
    for (int i = 0; i < DATA_W; i++) begin
      pos = data_pos(i);
      for (int b = 0; b < HAM_W; b++) begin
        if (pos[b]) chk[b] = chk[b] ^ data[i];
      end
    end
    // overall parity makes the whole codeword even
    chk[CHK_W-1] = ^{chk[HAM_W-1:0], data};
    return chk;
  endfunction

  // syndrome of a stored codeword
  // low bits point at the flipped position, top bit is the overall parity
  function automatic logic [CHK_W-1:0] secded_syndrome(logic [CODE_W-1:0] code);
    logic [CHK_W-1:0] chk;
    logic [CHK_W-1:0] syn;
    chk                = secded_encode(code[DATA_W-1:0]);
    syn[HAM_W-1:0]     = chk[HAM_W-1:0] ^ code[CODE_W-2:DATA_W];
    syn[CHK_W-1]       = ^code;
    return syn;
  endfunction

endpackage

//--- design/bank_sram.sv
module bank_sram (
    input  logic                                clk
  , input  logic                                write
  , input  logic                                read
  , input  logic [mem_cfg_pkg::BANK_ADDR_W-1:0] addr
  , input  logic [secded_pkg::CODE_W-1:0]       wdata
  , output logic [secded_pkg::CODE_W-1:0]       rdata
);

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  // one codeword per location, contents are undefined until written
  logic [CODE_W-1:0] mem [BANK_DEPTH];

  // single port, so the pipe never raises write and read together
  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= wdata;
    end
    // output register keeps the last read word until the next read
    // the pipe relies on that while it is stalled
    if (read) begin
      rdata <= mem[addr];
    end
  end

endmodule

//--- design/rw_pipe_core.sv
module rw_pipe_core (
    input  logic                                clk
  , input  logic                                arst_n
  , input  logic                                stall

  , input  logic                                in_v
  , input  mem_cfg_pkg::rw_cmd_e                in_cmd
  , input  logic [mem_cfg_pkg::BANK_ADDR_W-1:0] in_addr
  , input  logic [secded_pkg::CODE_W-1:0]       in_code

  , output logic                                mem_write
  , output logic                                mem_read
  , output logic [mem_cfg_pkg::BANK_ADDR_W-1:0] mem_addr
  , output logic [secded_pkg::CODE_W-1:0]       mem_wdata
  , input  logic [secded_pkg::CODE_W-1:0]       mem_rdata

  , output logic                                p2_v
  , output mem_cfg_pkg::rw_cmd_e                p2_cmd
  , output logic [mem_cfg_pkg::BANK_ADDR_W-1:0] p2_addr
  , output logic [secded_pkg::CODE_W-1:0]       p2_code
  , input  logic [secded_pkg::DATA_W-1:0]       p2_data
  , input  logic                                p2_err_sb
  , input  logic                                p2_err_mb

  , output logic                                p3_v
  , output logic [mem_cfg_pkg::BANK_ADDR_W-1:0] p3_addr
  , output logic [secded_pkg::DATA_W-1:0]       p3_data
  , output logic                                p3_err_sb
  , output logic                                p3_err_mb

  , output logic                                busy
);

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  logic                   p0_v;
  rw_cmd_e                p0_cmd;
  logic [BANK_ADDR_W-1:0] p0_addr;
  logic [CODE_W-1:0]      p0_code;

  logic                   p1_v;
  rw_cmd_e                p1_cmd;
  logic [BANK_ADDR_W-1:0] p1_addr;
  logic [CODE_W-1:0]      p1_code;

  // valid and command per stage, one global stall freezes all of them
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p0_v   <= 1'b0;
      p0_cmd <= CMD_NOP;
      p1_v   <= 1'b0;
      p1_cmd <= CMD_NOP;
      p2_v   <= 1'b0;
      p2_cmd <= CMD_NOP;
      p3_v   <= 1'b0;
    end else if (!stall) begin
      p0_v   <= in_v;
      p0_cmd <= in_cmd;
      p1_v   <= p0_v;
      p1_cmd <= p0_cmd;
      p2_v   <= p1_v;
      p2_cmd <= p1_cmd;
      // writes retire at p2, only reads produce a p3 result
      p3_v   <= p2_v && (p2_cmd == CMD_READ);
    end
  end

  // address, codeword and corrected data ride along with the valid bits
  always_ff @(posedge clk) begin
    if (!stall) begin
      p0_addr   <= in_addr;
      p0_code   <= in_code;
      p1_addr   <= p0_addr;
      p1_code   <= p0_code;
      p2_addr   <= p1_addr;
      p3_addr   <= p2_addr;
      p3_data   <= p2_data;
      p3_err_sb <= p2_err_sb;
      p3_err_mb <= p2_err_mb;
    end
  end

  // the RAM access is issued from p1 and lands on the edge that moves p1 into p2
  // a write here is seen by a read that sits in p1 one cycle later
  assign mem_write = p1_v && (p1_cmd == CMD_WRITE) && !stall;
  assign mem_read  = p1_v && (p1_cmd == CMD_READ) && !stall;
  assign mem_addr  = p1_addr;
  assign mem_wdata = p1_code;

  // the RAM output register acts as the p2 data register
  // it only changes on a read, so it holds along with p2 under stall
  assign p2_code   = mem_rdata;

  assign busy      = p0_v | p1_v | p2_v | p3_v;

endmodule

//--- design/secded_check.sv
module secded_check (
    input  logic [secded_pkg::CODE_W-1:0] code
  , input  logic                          check_v
  , output logic [secded_pkg::DATA_W-1:0] data
  , output logic                          err_sb
  , output logic                          err_mb
);

  import secded_pkg::*;

  logic [CHK_W-1:0] syn;

  assign syn = secded_syndrome(code);

  always_comb begin
    data   = code[DATA_W-1:0];
    err_sb = 1'b0;
    err_mb = 1'b0;
    if (check_v && (syn != '0)) begin
      if (!syn[CHK_W-1]) begin
        // parity still even but the hamming bits disagree, two bits flipped
        err_mb = 1'b1;
      end else if (syn[HAM_W-1:0] >= HAM_W'(CODE_W)) begin
        // odd parity pointing past the last position cannot be a single flip
        err_mb = 1'b1;
      end else begin
        err_sb = 1'b1;
        // a syndrome of zero or a power of two hits a check bit
        // so the data passes through untouched in that case
        for (int i = 0; i < DATA_W; i++) begin
          if (data_pos(i) == syn[HAM_W-1:0]) begin
            data[i] = ~code[i];
          end
        end
      end
    end
  end

endmodule

//--- design/ecc_mem_bank.sv
module ecc_mem_bank (
    input  logic                                clk
  , input  logic                                arst_n
  , input  logic                                stall

  , input  logic                                in_v
  , input  mem_cfg_pkg::rw_cmd_e                in_cmd
  , input  logic [mem_cfg_pkg::BANK_ADDR_W-1:0] in_addr
  , input  logic [secded_pkg::DATA_W-1:0]       in_wdata
  , input  logic                                in_inj_sb
  , input  logic                                in_inj_mb

  , output logic                                out_v
  , output logic [mem_cfg_pkg::BANK_ADDR_W-1:0] out_addr
  , output logic [secded_pkg::DATA_W-1:0]       out_data
  , output logic                                out_err_sb
  , output logic                                out_err_mb
  , output logic                                out_busy
);

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  logic [CHK_W-1:0]       wr_chk;
  logic [CODE_W-1:0]      wr_code;
  logic [CODE_W-1:0]      inj_mask;

  logic                   mem_write;
  logic                   mem_read;
  logic [BANK_ADDR_W-1:0] mem_addr;
  logic [CODE_W-1:0]      mem_wdata;
  logic [CODE_W-1:0]      mem_rdata;

  logic                   p2_v;
  rw_cmd_e                p2_cmd;
  logic [CODE_W-1:0]      p2_code;
  logic                   check_v;
  logic [DATA_W-1:0]      chk_data;
  logic                   chk_sb;
  logic                   chk_mb;

  // encode on entry so the pipe only ever carries full codewords
  assign wr_chk   = secded_encode(in_wdata);
  // debug injection flips bit 0 alone for a single error and bits 0 and 1 for a double
  assign inj_mask = {{(CODE_W-2){1'b0}}, in_inj_mb, in_inj_sb | in_inj_mb};
  assign wr_code  = {wr_chk, in_wdata} ^ inj_mask;

  rw_pipe_core u_core (
      .clk       ( clk )
    , .arst_n    ( arst_n )
    , .stall     ( stall )
    , .in_v      ( in_v )
    , .in_cmd    ( in_cmd )
    , .in_addr   ( in_addr )
    , .in_code   ( wr_code )
    , .mem_write ( mem_write )
    , .mem_read  ( mem_read )
    , .mem_addr  ( mem_addr )
    , .mem_wdata ( mem_wdata )
    , .mem_rdata ( mem_rdata )
    , .p2_v      ( p2_v )
    , .p2_cmd    ( p2_cmd )
    , .p2_addr   ( )
    , .p2_code   ( p2_code )
    , .p2_data   ( chk_data )
    , .p2_err_sb ( chk_sb )
    , .p2_err_mb ( chk_mb )
    , .p3_v      ( out_v )
    , .p3_addr   ( out_addr )
    , .p3_data   ( out_data )
    , .p3_err_sb ( out_err_sb )
    , .p3_err_mb ( out_err_mb )
    , .busy      ( out_busy )
  );

  bank_sram u_sram (
      .clk   ( clk )
    , .write ( mem_write )
    , .read  ( mem_read )
    , .addr  ( mem_addr )
    , .wdata ( mem_wdata )
    , .rdata ( mem_rdata )
  );

  // the RAM output is stale for writes and bubbles, so only a read at p2 is checked
  assign check_v = p2_v && (p2_cmd == CMD_READ);

  secded_check u_check (
      .code    ( p2_code )
    , .check_v ( check_v )
    , .data    ( chk_data )
    , .err_sb  ( chk_sb )
    , .err_mb  ( chk_mb )
  );

endmodule

//--- design/req_steer.sv
module req_steer (
    input  logic                                clk
  , input  logic                                arst_n
  , input  logic                                stall

  , input  logic                                req_v
  , input  mem_cfg_pkg::rw_cmd_e                req_cmd
  , input  logic [mem_cfg_pkg::ADDR_W-1:0]      req_addr
  , input  logic [secded_pkg::DATA_W-1:0]       req_wdata
  , input  logic                                inj_sb
  , input  logic                                inj_mb

  , output logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_v
  , output mem_cfg_pkg::rw_cmd_e                bank_cmd
  , output logic [mem_cfg_pkg::BANK_ADDR_W-1:0] bank_addr
  , output logic [secded_pkg::DATA_W-1:0]       bank_wdata
  , output logic                                bank_inj_sb
  , output logic                                bank_inj_mb
  , output logic                                busy_in
);

  import mem_cfg_pkg::*;

  logic                 accept;
  logic [NUM_BANKS-1:0] sel_oh;

  // requests during stall are ignored, a NOP never reaches a bank
  assign accept = req_v && !stall && (req_cmd != CMD_NOP);

  // one-hot bank valid from the top address bits
  always_comb begin
    sel_oh = '0;
    sel_oh[req_addr[ADDR_W-1 -: BANK_SEL_W]] = accept;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bank_v   <= '0;
      bank_cmd <= CMD_NOP;
    end else if (!stall) begin
      bank_v   <= sel_oh;
      bank_cmd <= req_cmd;
    end
  end

  // shared fields fan out to every bank, only the valid bit is per bank
  always_ff @(posedge clk) begin
    if (!stall) begin
      bank_addr   <= req_addr[BANK_ADDR_W-1:0];
      bank_wdata  <= req_wdata;
      // injection only means something on a write
      bank_inj_sb <= inj_sb && (req_cmd == CMD_WRITE);
      bank_inj_mb <= inj_mb && (req_cmd == CMD_WRITE);
    end
  end

  assign busy_in = |bank_v;

endmodule

//--- design/rsp_merge.sv
module rsp_merge (
    input  logic                                clk
  , input  logic                                arst_n
  , input  logic                                stall

  , input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_v
  , input  logic [mem_cfg_pkg::BANK_ADDR_W-1:0] bank_addr [mem_cfg_pkg::NUM_BANKS]
  , input  logic [secded_pkg::DATA_W-1:0]       bank_data [mem_cfg_pkg::NUM_BANKS]
  , input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_err_sb
  , input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_err_mb

  , output logic                                rsp_v
  , output logic [mem_cfg_pkg::ADDR_W-1:0]      rsp_addr
  , output logic [secded_pkg::DATA_W-1:0]       rsp_data
  , output logic                                rsp_err_sb
  , output logic                                rsp_err_mb
  , output logic [mem_cfg_pkg::CNT_W-1:0]       cnt_sb
  , output logic [mem_cfg_pkg::CNT_W-1:0]       cnt_mb
  , output logic                                busy_out
);

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  logic              sel_v;
  logic [ADDR_W-1:0] sel_addr;
  logic [DATA_W-1:0] sel_data;
  logic              sel_sb;
  logic              sel_mb;
  logic              rsp_q_v;

  // one request enters per cycle, so at most one bank shows a read here
  always_comb begin
    sel_v    = 1'b0;
    sel_addr = '0;
    sel_data = '0;
    sel_sb   = 1'b0;
    sel_mb   = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_v[i]) begin
        sel_v    = 1'b1;
        // the bank index goes back on top to rebuild the request address
        sel_addr = {BANK_SEL_W'(i), bank_addr[i]};
        sel_data = bank_data[i];
        sel_sb   = bank_err_sb[i];
        sel_mb   = bank_err_mb[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_q_v    <= 1'b0;
      rsp_err_sb <= 1'b0;
      rsp_err_mb <= 1'b0;
      cnt_sb     <= '0;
      cnt_mb     <= '0;
    end else if (!stall) begin
      rsp_q_v    <= sel_v;
      rsp_err_sb <= sel_v && sel_sb;
      rsp_err_mb <= sel_v && sel_mb;
      // counters saturate instead of wrapping
      if (sel_v && sel_sb && (cnt_sb != '1)) cnt_sb <= cnt_sb + 1'b1;
      if (sel_v && sel_mb && (cnt_mb != '1)) cnt_mb <= cnt_mb + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      rsp_addr <= sel_addr;
      rsp_data <= sel_data;
    end
  end

  // a held response is shown in the first cycle without stall, then replaced
  assign rsp_v    = rsp_q_v && !stall;
  assign busy_out = rsp_q_v;

endmodule

//--- design/ecc_bank_array.sv
module ecc_bank_array (
    input  logic                                clk
  , input  logic                                arst_n
  , input  logic                                stall

  , input  logic                                req_v
  , input  mem_cfg_pkg::rw_cmd_e                req_cmd
  , input  logic [mem_cfg_pkg::ADDR_W-1:0]      req_addr
  , input  logic [secded_pkg::DATA_W-1:0]       req_wdata
  , input  logic                                inj_sb
  , input  logic                                inj_mb

  , output logic                                rsp_v
  , output logic [mem_cfg_pkg::ADDR_W-1:0]      rsp_addr
  , output logic [secded_pkg::DATA_W-1:0]       rsp_data
  , output logic                                rsp_err_sb
  , output logic                                rsp_err_mb
  , output logic [mem_cfg_pkg::CNT_W-1:0]       cnt_sb
  , output logic [mem_cfg_pkg::CNT_W-1:0]       cnt_mb
  , output logic                                busy
);

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  // request side, one valid per bank plus shared fields
  logic [NUM_BANKS-1:0]   bank_v;
  rw_cmd_e                bank_cmd;
  logic [BANK_ADDR_W-1:0] bank_addr;
  logic [DATA_W-1:0]      bank_wdata;
  logic                   bank_inj_sb;
  logic                   bank_inj_mb;
  logic                   busy_in;

  // response side, one p3 result per bank
  logic [NUM_BANKS-1:0]   rd_v;
  logic [BANK_ADDR_W-1:0] rd_addr [NUM_BANKS];
  logic [DATA_W-1:0]      rd_data [NUM_BANKS];
  logic [NUM_BANKS-1:0]   rd_err_sb;
  logic [NUM_BANKS-1:0]   rd_err_mb;
  logic [NUM_BANKS-1:0]   bank_busy;
  logic                   busy_out;

  req_steer u_steer (
      .clk         ( clk )
    , .arst_n      ( arst_n )
    , .stall       ( stall )
    , .req_v       ( req_v )
    , .req_cmd     ( req_cmd )
    , .req_addr    ( req_addr )
    , .req_wdata   ( req_wdata )
    , .inj_sb      ( inj_sb )
    , .inj_mb      ( inj_mb )
    , .bank_v      ( bank_v )
    , .bank_cmd    ( bank_cmd )
    , .bank_addr   ( bank_addr )
    , .bank_wdata  ( bank_wdata )
    , .bank_inj_sb ( bank_inj_sb )
    , .bank_inj_mb ( bank_inj_mb )
    , .busy_in     ( busy_in )
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    ecc_mem_bank u_bank (
        .clk        ( clk )
      , .arst_n     ( arst_n )
      , .stall      ( stall )
      , .in_v       ( bank_v[b] )
      , .in_cmd     ( bank_cmd )
      , .in_addr    ( bank_addr )
      , .in_wdata   ( bank_wdata )
      , .in_inj_sb  ( bank_inj_sb )
      , .in_inj_mb  ( bank_inj_mb )
      , .out_v      ( rd_v[b] )
      , .out_addr   ( rd_addr[b] )
      , .out_data   ( rd_data[b] )
      , .out_err_sb ( rd_err_sb[b] )
      , .out_err_mb ( rd_err_mb[b] )
      , .out_busy   ( bank_busy[b] )
    );
  end

  rsp_merge u_merge (
      .clk         ( clk )
    , .arst_n      ( arst_n )
    , .stall       ( stall )
    , .bank_v      ( rd_v )
    , .bank_addr   ( rd_addr )
    , .bank_data   ( rd_data )
    , .bank_err_sb ( rd_err_sb )
    , .bank_err_mb ( rd_err_mb )
    , .rsp_v       ( rsp_v )
    , .rsp_addr    ( rsp_addr )
    , .rsp_data    ( rsp_data )
    , .rsp_err_sb  ( rsp_err_sb )
    , .rsp_err_mb  ( rsp_err_mb )
    , .cnt_sb      ( cnt_sb )
    , .cnt_mb      ( cnt_mb )
    , .busy_out    ( busy_out )
  );

  // anything still in flight anywhere keeps busy up
  assign busy = busy_in | (|bank_busy) | busy_out;

endmodule

//--- tb/tb_ecc_bank_array.sv
module tb_ecc_bank_array;

  timeunit 1ns;
  timeprecision 100ps;

  import mem_cfg_pkg::*;
  import secded_pkg::*;

  localparam int TEST_CYCLES    = 2000;
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 200;
  // cycles from driving a request until its response shows on rsp_v
  localparam int PIPE_LAT       = 6;
  localparam int WORDS          = NUM_BANKS * BANK_DEPTH;
  localparam int CNT_MAX        = (1 << CNT_W) - 1;

  logic              clk;
  logic              arst_n;
  logic              stall;
  logic              req_v;
  rw_cmd_e           req_cmd;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic              inj_sb;
  logic              inj_mb;
  logic              rsp_v;
  logic [ADDR_W-1:0] rsp_addr;
  logic [DATA_W-1:0] rsp_data;
  logic              rsp_err_sb;
  logic              rsp_err_mb;
  logic [CNT_W-1:0]  cnt_sb;
  logic [CNT_W-1:0]  cnt_mb;
  logic              busy;

  // reference model of the memory contents and of the injected faults per word
  logic [DATA_W-1:0] model_data [WORDS];
  bit                model_sb [WORDS];
  bit                model_mb [WORDS];
  bit                model_written [WORDS];
  int                written_addrs [$];

  // expected responses in request order with the live cycle each one is due in
  logic [ADDR_W-1:0] exp_addr [$];
  logic [DATA_W-1:0] exp_data [$];
  bit                exp_sb [$];
  bit                exp_mb [$];
  int                exp_due [$];

  integer            seed;
  int                cycle_cnt;
  // counts cycles without stall because the pipe only advances in those
  int                live_cnt;
  int                model_cnt_sb;
  int                model_cnt_mb;

  ecc_bank_array u_ecc_bank_array (
      .clk        ( clk )
    , .arst_n     ( arst_n )
    , .stall      ( stall )
    , .req_v      ( req_v )
    , .req_cmd    ( req_cmd )
    , .req_addr   ( req_addr )
    , .req_wdata  ( req_wdata )
    , .inj_sb     ( inj_sb )
    , .inj_mb     ( inj_mb )
    , .rsp_v      ( rsp_v )
    , .rsp_addr   ( rsp_addr )
    , .rsp_data   ( rsp_data )
    , .rsp_err_sb ( rsp_err_sb )
    , .rsp_err_mb ( rsp_err_mb )
    , .cnt_sb     ( cnt_sb )
    , .cnt_mb     ( cnt_mb )
    , .busy       ( busy )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int saturate_count(int n);
    return (n > CNT_MAX) ? CNT_MAX : n;
  endfunction

  task automatic idle_cycle();
    req_v   = 1'b0;
    req_cmd = CMD_NOP;
    inj_sb  = 1'b0;
    inj_mb  = 1'b0;
    stall   = 1'b0;
    live_cnt++;
  endtask

  // a small window per bank so words get rewritten and faults get cleared again
  task automatic drive_write();
    int                a;
    int                kind;
    logic [DATA_W-1:0] d;
    a         = rand_below(NUM_BANKS) * BANK_DEPTH + rand_below(64);
    d         = DATA_W'($random(seed));
    kind      = rand_below(32);
    req_v     = 1'b1;
    req_cmd   = CMD_WRITE;
    req_addr  = ADDR_W'(a);
    req_wdata = d;
    inj_sb    = (kind == 0);
    inj_mb    = (kind == 1);
    model_data[a] = d;
    model_sb[a]   = (kind == 0);
    model_mb[a]   = (kind == 1);
    if (!model_written[a]) begin
      model_written[a] = 1'b1;
      written_addrs.push_back(a);
    end
  endtask

  task automatic drive_read();
    int a;
    a         = written_addrs[rand_below(written_addrs.size())];
    req_v     = 1'b1;
    req_cmd   = CMD_READ;
    req_addr  = ADDR_W'(a);
    req_wdata = DATA_W'($random(seed));
    // injection lines carry noise here and a read must ignore them
    inj_sb    = (rand_below(8) == 0);
    inj_mb    = (rand_below(8) == 0);
    exp_addr.push_back(ADDR_W'(a));
    exp_data.push_back(model_data[a]);
    exp_sb.push_back(model_sb[a]);
    exp_mb.push_back(model_mb[a]);
    exp_due.push_back(live_cnt + PIPE_LAT);
  endtask

  task automatic drive_cycle();
    int pick;
    pick = rand_below(100);
    if (pick < 15) begin
      idle_cycle();
      live_cnt--;
      stall = 1'b1;
      // a stray request under stall has to be dropped by the input stage
      if (rand_below(2) == 0) begin
        req_v    = 1'b1;
        req_cmd  = (rand_below(2) == 0) ? CMD_READ : CMD_WRITE;
        req_addr = ADDR_W'($random(seed));
      end
    end else if (pick < 30) begin
      idle_cycle();
    end else begin
      idle_cycle();
      if (pick < 60 || written_addrs.size() == 0) begin
        drive_write();
      end else begin
        drive_read();
      end
    end
  endtask

  task automatic check_cycle();
    if (stall) begin
      assert (!rsp_v) else value_error("rsp_v high during a stall cycle");
    end else if (rsp_v) begin
      assert (exp_due.size() != 0) else value_error("response with no read outstanding");
      if (exp_due.size() != 0) begin
        assert (exp_due[0] == live_cnt)
          else value_error($sformatf("response at live cycle %0d, due at %0d",
                                     live_cnt, exp_due[0]));
        assert (rsp_addr == exp_addr[0])
          else value_error($sformatf("rsp_addr %0h, expected %0h", rsp_addr, exp_addr[0]));
        assert (rsp_err_sb == exp_sb[0] && rsp_err_mb == exp_mb[0])
          else value_error($sformatf("flags sb %0b mb %0b, expected sb %0b mb %0b",
                                     rsp_err_sb, rsp_err_mb, exp_sb[0], exp_mb[0]));
        // a double error leaves the data unrecoverable
        if (!exp_mb[0]) begin
          assert (rsp_data == exp_data[0])
            else value_error($sformatf("rsp_data %0h at %0h, expected %0h",
                                       rsp_data, rsp_addr, exp_data[0]));
        end
        if (exp_sb[0]) model_cnt_sb++;
        if (exp_mb[0]) model_cnt_mb++;
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_sb.pop_front());
        void'(exp_mb.pop_front());
        void'(exp_due.pop_front());
      end
    end else begin
      assert (exp_due.size() == 0 || exp_due[0] != live_cnt)
        else value_error("expected read response did not arrive");
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("the run timed out after %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  initial begin
    seed         = 68;
    live_cnt     = 0;
    model_cnt_sb = 0;
    model_cnt_mb = 0;
    arst_n       = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    idle_cycle();
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    assert (!rsp_v && !busy) else value_error("rsp_v or busy high after reset");
    assert (cnt_sb == '0 && cnt_mb == '0) else value_error("error counters not zero after reset");

    repeat (TEST_CYCLES) begin
      @(posedge clk);
      #2;
      drive_cycle();
      @(negedge clk);
      check_cycle();
    end

    // drain every read still in flight
    while (exp_due.size() != 0 || busy) begin
      @(posedge clk);
      #2;
      idle_cycle();
      @(negedge clk);
      check_cycle();
    end
    // a few quiet cycles catch any late stray response
    repeat (4) begin
      @(posedge clk);
      #2;
      idle_cycle();
      @(negedge clk);
      check_cycle();
      assert (!rsp_v && !busy) else value_error("rsp_v or busy high after the pipe drained");
    end

    assert (cnt_sb == CNT_W'(saturate_count(model_cnt_sb)))
      else value_error($sformatf("cnt_sb %0d, expected %0d", cnt_sb,
                                 saturate_count(model_cnt_sb)));
    assert (cnt_mb == CNT_W'(saturate_count(model_cnt_mb)))
      else value_error($sformatf("cnt_mb %0d, expected %0d", cnt_mb,
                                 saturate_count(model_cnt_mb)));

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- ecc_bank_array.f
design/mem_cfg_pkg.sv
design/secded_pkg.sv
design/bank_sram.sv
design/rw_pipe_core.sv
design/secded_check.sv
design/ecc_mem_bank.sv
design/req_steer.sv
design/rsp_merge.sv
design/ecc_bank_array.sv
tb/tb_ecc_bank_array.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ecc_bank_array \
  -f ecc_bank_array.f -o tb_sim \
  && ./obj_dir/tb_sim \
  || { echo "simulation did not complete cleanly"; exit 1; }
